// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_banked_mem
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/bank_pkg.sv ====
package bank_pkg;

  // width of one lane and of one bank word
  localparam int unsigned LANE_DW = 32;

  // bits per byte for byte-enable slicing
  localparam int unsigned BYTE_W = 8;

  // byte enables carried by one lane
  localparam int unsigned LANE_BW = LANE_DW / BYTE_W;

  // low address bits selecting a byte inside a word
  // the banks see word addresses only and drop these
  localparam int unsigned BYTE_OFS_W = $clog2(LANE_BW);

  // default build of the scratchpad
  localparam int unsigned DEF_NB_BANKS = 8;
  localparam int unsigned DEF_WIDE_DW = 128;
  localparam int unsigned DEF_ROW_AW = 6;

  // 0 builds the request FIFO as a plain bypass
  localparam int unsigned DEF_FIFO_DEPTH = 2;

endpackage

// ==== common/tcdm_if.sv ====
interface tcdm_if #(
  parameter int unsigned DW = bank_pkg::LANE_DW,
  parameter int unsigned AW = 32
);

  // one byte enable per data byte
  localparam int unsigned BW = DW / 8;

  // request channel, held until gnt
  logic          req;
  logic          gnt;
  logic [AW-1:0] add;
  // high for a read, low for a write
  logic          wen;
  logic [BW-1:0] be;
  logic [DW-1:0] data;

  // response channel, one cycle after the grant of a read
  logic [DW-1:0] r_data;
  logic          r_valid;

  modport initiator (
    output req, add, wen, be, data,
    input  gnt, r_data, r_valid
  );

  modport target (
    input  req, add, wen, be, data,
    output gnt, r_data, r_valid
  );

endinterface

// ==== router/bank_rotator.sv ====
module bank_rotator #(
  parameter int unsigned NB_BANKS = 8,
  parameter int unsigned WIDE_DW = 128,
  parameter int unsigned ROW_AW = 6
) (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic [$clog2(NB_BANKS)-1:0] bank_ofs_i,

  tcdm_if.target    lane [0:WIDE_DW/bank_pkg::LANE_DW-1],
  tcdm_if.initiator bank [0:NB_BANKS-1]
);

  localparam int unsigned NB_LANES = WIDE_DW / bank_pkg::LANE_DW;
  localparam int unsigned BOFS_W = $clog2(NB_BANKS);
  localparam int unsigned LANE_IW = (NB_LANES > 1) ? $clog2(NB_LANES) : 1;

  // flattened lane side, so the crossbar can index by offset
  logic [NB_LANES-1:0]                          l_req;
  logic [NB_LANES-1:0]                          l_wen;
  logic [NB_LANES-1:0][ROW_AW-1:0]              l_add;
  logic [NB_LANES-1:0][bank_pkg::LANE_BW-1:0]   l_be;
  logic [NB_LANES-1:0][bank_pkg::LANE_DW-1:0]   l_data;
  // flattened bank side
  logic [NB_BANKS-1:0]                          b_gnt;
  logic [NB_BANKS-1:0]                          b_rvalid;
  logic [NB_BANKS-1:0][bank_pkg::LANE_DW-1:0]   b_rdata;
  // offset of the granted request, for the response one cycle later
  logic [BOFS_W-1:0]                            ofs_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ofs_q <= '0;
    end else begin
      ofs_q <= bank_ofs_i;
    end
  end

  for (genvar k = 0; k < NB_LANES; k++) begin : gen_lane_side
    assign l_req[k]  = lane[k].req;
    assign l_wen[k]  = lane[k].wen;
    assign l_add[k]  = lane[k].add;
    assign l_be[k]   = lane[k].be;
    assign l_data[k] = lane[k].data;

    // lane k sits on bank (ofs + k), the modulo is the index wrap
    assign lane[k].gnt     = b_gnt[bank_ofs_i + BOFS_W'(k)];
    assign lane[k].r_valid = b_rvalid[ofs_q + BOFS_W'(k)];
    assign lane[k].r_data  = b_rdata[ofs_q + BOFS_W'(k)];
  end

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank_side
    // lane that lands on this bank, if any
    logic [BOFS_W-1:0]  idx;
    logic [LANE_IW-1:0] sel;

    assign idx = BOFS_W'(b) - bank_ofs_i;
    assign sel = LANE_IW'(idx);

    always_comb begin
      if (idx < BOFS_W'(NB_LANES)) begin
        bank[b].req  = l_req[sel];
        bank[b].wen  = l_wen[sel];
        bank[b].add  = l_add[sel];
        bank[b].be   = l_be[sel];
        bank[b].data = l_data[sel];
      end else begin
        // no lane mapped, bank stays idle
        bank[b].req  = 1'b0;
        bank[b].wen  = 1'b1;
        bank[b].add  = '0;
        bank[b].be   = '0;
        bank[b].data = '0;
      end
    end

    assign b_gnt[b]    = bank[b].gnt;
    assign b_rvalid[b] = bank[b].r_valid;
    assign b_rdata[b]  = bank[b].r_data;
  end

endmodule

// ==== router/wide_router.sv ====
module wide_router #(
  parameter int unsigned NB_BANKS = 8,
  parameter int unsigned WIDE_DW = 128,
  parameter int unsigned ROW_AW = 6
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,

  tcdm_if.target    wide,
  tcdm_if.initiator lane [0:WIDE_DW/bank_pkg::LANE_DW-1],

  output logic [$clog2(NB_BANKS)-1:0] bank_ofs_o
);

  localparam int unsigned NB_LANES = WIDE_DW / bank_pkg::LANE_DW;
  localparam int unsigned BOFS_W = $clog2(NB_BANKS);
  // one extra bit so offset plus lane index cannot overflow
  localparam int unsigned SUM_W = BOFS_W + 1;
  localparam int unsigned AW = ROW_AW + BOFS_W + bank_pkg::BYTE_OFS_W;

  logic [BOFS_W-1:0]   bank_ofs;
  logic [ROW_AW-1:0]   row;
  logic [NB_LANES-1:0] lane_gnt;
  logic [NB_LANES-1:0] lane_rvalid;
  // grant of the previous cycle qualifies the response
  logic                gnt_q;

  // word-interleaved address map
  // byte offset at the bottom with the bank above it and the row on top
  assign bank_ofs   = wide.add[bank_pkg::BYTE_OFS_W +: BOFS_W];
  assign row        = wide.add[AW-1 -: ROW_AW];
  assign bank_ofs_o = bank_ofs;

  for (genvar ii = 0; ii < NB_LANES; ii++) begin : gen_lane
    // bank this lane would hit before the modulo
    logic [SUM_W-1:0] bank_sum;

    assign bank_sum = SUM_W'(bank_ofs) + SUM_W'(ii);

    // handshake and opcode are shared by all lanes
    assign lane[ii].req  = wide.req;
    assign lane[ii].wen  = wide.wen;
    assign lane[ii].be   = wide.be[ii*bank_pkg::LANE_BW +: bank_pkg::LANE_BW];
    assign lane[ii].data = wide.data[ii*bank_pkg::LANE_DW +: bank_pkg::LANE_DW];

    // lanes wrapping past the last bank continue in the next row
    assign lane[ii].add = (bank_sum >= SUM_W'(NB_BANKS)) ? row + 1'b1 : row;

    assign wide.r_data[ii*bank_pkg::LANE_DW +: bank_pkg::LANE_DW] = lane[ii].r_data;

    assign lane_gnt[ii]    = lane[ii].gnt;
    assign lane_rvalid[ii] = lane[ii].r_valid;
  end

  // lane 0 speaks for the whole word
  assign wide.gnt = lane_gnt[0] & wide.req;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else if (clear_i) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= lane_gnt[0] & wide.req;
    end
  end

  // response only in the cycle right after a grant
  assign wide.r_valid = lane_rvalid[0] & gnt_q;

  // the rotator needs a distinct bank for every lane
  if (NB_LANES > NB_BANKS) begin : gen_cfg_err
    $error("wide_router: more lanes than banks");
  end

  // no lane may be granted apart from the others
  a_lane_gnt_sync : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wide.req |-> (lane_gnt == {NB_LANES{lane_gnt[0]}}));

  // responses of all lanes come back in the same cycle
  a_lane_rvalid_sync : assert property (@(posedge clk_i) disable iff (!rst_ni)
    lane_rvalid == {NB_LANES{lane_rvalid[0]}});

endmodule

// ==== rtl/banked_mem_top.sv ====
module banked_mem_top #(
  parameter int unsigned NB_BANKS = bank_pkg::DEF_NB_BANKS,
  parameter int unsigned WIDE_DW = bank_pkg::DEF_WIDE_DW,
  parameter int unsigned ROW_AW = bank_pkg::DEF_ROW_AW,
  parameter int unsigned FIFO_DEPTH = bank_pkg::DEF_FIFO_DEPTH,
  localparam int unsigned AW = ROW_AW + $clog2(NB_BANKS) + bank_pkg::BYTE_OFS_W,
  localparam int unsigned WIDE_BW = WIDE_DW / 8
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,

  input  logic               req_i,
  input  logic [AW-1:0]      add_i,
  input  logic               wen_i,
  input  logic [WIDE_BW-1:0] be_i,
  input  logic [WIDE_DW-1:0] data_i,
  output logic               gnt_o,
  output logic [WIDE_DW-1:0] r_data_o,
  output logic               r_valid_o
);

  localparam int unsigned NB_LANES = WIDE_DW / bank_pkg::LANE_DW;

  logic [$clog2(NB_BANKS)-1:0] bank_ofs;

  // wide port as seen from outside, and after the FIFO
  tcdm_if #(.DW(WIDE_DW), .AW(AW)) wide_bus ();
  tcdm_if #(.DW(WIDE_DW), .AW(AW)) post_fifo ();
  // 32-bit lanes and banks carry only the row address
  tcdm_if #(.DW(bank_pkg::LANE_DW), .AW(ROW_AW)) lane [0:NB_LANES-1] ();
  tcdm_if #(.DW(bank_pkg::LANE_DW), .AW(ROW_AW)) bank [0:NB_BANKS-1] ();

  assign wide_bus.req  = req_i;
  assign wide_bus.add  = add_i;
  assign wide_bus.wen  = wen_i;
  assign wide_bus.be   = be_i;
  assign wide_bus.data = data_i;
  assign gnt_o         = wide_bus.gnt;
  assign r_data_o      = wide_bus.r_data;
  assign r_valid_o     = wide_bus.r_valid;

  req_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .NB_BANKS  (NB_BANKS),
    .WIDE_DW   (WIDE_DW),
    .ROW_AW    (ROW_AW)
  ) req_fifo_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(clear_i),
    .tgt    (wide_bus),
    .ini    (post_fifo)
  );

  wide_router #(
    .NB_BANKS(NB_BANKS),
    .WIDE_DW (WIDE_DW),
    .ROW_AW  (ROW_AW)
  ) wide_router_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clear_i   (clear_i),
    .wide      (post_fifo),
    .lane      (lane),
    .bank_ofs_o(bank_ofs)
  );

  bank_rotator #(
    .NB_BANKS(NB_BANKS),
    .WIDE_DW (WIDE_DW),
    .ROW_AW  (ROW_AW)
  ) bank_rotator_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bank_ofs_i(bank_ofs),
    .lane      (lane),
    .bank      (bank)
  );

  // one single-port bank per interleave slot
  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
    sram_bank #(
      .ROW_AW(ROW_AW)
    ) sram_bank_i (
      .clk_i (clk_i),
      .rst_ni(rst_ni),
      .port  (bank[b])
    );
  end

endmodule

// ==== rtl/req_fifo.sv ====
module req_fifo #(
  parameter int unsigned FIFO_DEPTH = 2,
  parameter int unsigned NB_BANKS = 8,
  parameter int unsigned WIDE_DW = 128,
  parameter int unsigned ROW_AW = 6
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,

  tcdm_if.target    tgt,
  tcdm_if.initiator ini
);

  localparam int unsigned AW = ROW_AW + $clog2(NB_BANKS) + bank_pkg::BYTE_OFS_W;

  if (FIFO_DEPTH == 0) begin : gen_bypass
    // no storage between the initiator and the router
    assign ini.req    = tgt.req;
    assign ini.add    = tgt.add;
    assign ini.wen    = tgt.wen;
    assign ini.be     = tgt.be;
    assign ini.data   = tgt.data;
    assign tgt.gnt    = ini.gnt;
    assign tgt.r_data  = ini.r_data;
    assign tgt.r_valid = ini.r_valid;
  end else begin : gen_fifo
    // one entry holds the whole request word
    localparam int unsigned ENTRY_W = AW + 1 + WIDE_DW / 8 + WIDE_DW;
    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [ENTRY_W-1:0] buf_q [FIFO_DEPTH];
    logic [ENTRY_W-1:0] head;
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               push;
    logic               pop;
    logic               full;
    logic               empty;
    logic               rd_issue;
    // reads sent downstream whose data has not come back yet
    logic [1:0]         inflight_q;
    logic               rsp_valid_q;
    logic [WIDE_DW-1:0] rsp_data_q;

    assign full  = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty = (count_q == '0);

    // accept while there is room
    assign tgt.gnt = ~full;
    assign push    = tgt.req & tgt.gnt;

    // head entry is offered as soon as it is stored
    assign ini.req = ~empty;
    assign pop     = ini.req & ini.gnt;
    assign head    = buf_q[rd_ptr_q];
    assign {ini.add, ini.wen, ini.be, ini.data} = head;

    // payload storage
    always_ff @(posedge clk_i) begin
      if (push) begin
        buf_q[wr_ptr_q] <= {tgt.add, tgt.wen, tgt.be, tgt.data};
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else if (clear_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        // circular pointers wrap at the depth
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        if (push && !pop) begin
          count_q <= count_q + 1'b1;
        end else if (pop && !push) begin
          count_q <= count_q - 1'b1;
        end
      end
    end

    // only reads produce a response
    assign rd_issue = pop & ini.wen;

    // the downstream answers in issue order
    // a counter tracks reads in flight and the response register keeps grant order
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        inflight_q  <= '0;
        rsp_valid_q <= 1'b0;
      end else if (clear_i) begin
        inflight_q  <= '0;
        rsp_valid_q <= 1'b0;
      end else begin
        inflight_q  <= inflight_q + {1'b0, rd_issue} - {1'b0, ini.r_valid};
        rsp_valid_q <= ini.r_valid;
      end
    end

    always_ff @(posedge clk_i) begin
      if (ini.r_valid) begin
        rsp_data_q <= ini.r_data;
      end
    end

    assign tgt.r_valid = rsp_valid_q;
    assign tgt.r_data  = rsp_data_q;

    // pointers meet only on an empty or a full queue
    a_ptr_count : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (wr_ptr_q == rd_ptr_q) == (empty || full));

    // every response from the router belongs to a read still in flight
    a_rvalid_inflight : assert property (@(posedge clk_i) disable iff (!rst_ni)
      ini.r_valid |-> (inflight_q != '0));
  end

endmodule

// ==== rtl/sram_bank.sv ====
module sram_bank #(
  parameter int unsigned ROW_AW = 6
) (
  input  logic clk_i,
  input  logic rst_ni,

  tcdm_if.target port
);

  localparam int unsigned NB_WORDS = 2 ** ROW_AW;

  logic [bank_pkg::LANE_DW-1:0] mem_q [NB_WORDS];
  logic [bank_pkg::LANE_DW-1:0] r_data_q;
  logic                         r_valid_q;
  logic                         rd_req;

  // single port that never stalls
  assign port.gnt = port.req;
  assign rd_req   = port.req & port.wen;

  // storage and read data path
  always_ff @(posedge clk_i) begin
    if (port.req && !port.wen) begin
      // write only the enabled bytes
      for (int i = 0; i < bank_pkg::LANE_BW; i++) begin
        if (port.be[i]) begin
          mem_q[port.add][i*bank_pkg::BYTE_W +: bank_pkg::BYTE_W] <=
            port.data[i*bank_pkg::BYTE_W +: bank_pkg::BYTE_W];
        end
      end
    end
    if (rd_req) begin
      r_data_q <= mem_q[port.add];
    end
  end

  // read response one cycle after the grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_req;
    end
  end

  assign port.r_valid = r_valid_q;
  assign port.r_data  = r_data_q;

endmodule

// ==== sources.f ====
common/bank_pkg.sv
common/tcdm_if.sv
rtl/sram_bank.sv
rtl/req_fifo.sv
router/bank_rotator.sv
router/wide_router.sv
rtl/banked_mem_top.sv
verif/tb_banked_mem.sv

// ==== verif/tb_banked_mem.sv ====
module tb_banked_mem;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NB_BANKS = 8;
  localparam int unsigned WIDE_DW = 128;
  localparam int unsigned ROW_AW = 6;
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned AW = ROW_AW + $clog2(NB_BANKS) + bank_pkg::BYTE_OFS_W;
  localparam int unsigned WIDE_BW = WIDE_DW / 8;
  // five numbers per access line in the pattern file
  localparam int unsigned FIELDS = 5;
  localparam int unsigned MAX_STEPS = 64;
  localparam int unsigned TIMEOUT = 50;

  // access kinds of the pattern file
  localparam logic [3:0] OP_WRITE = 4'h0;
  localparam logic [3:0] OP_READ = 4'h1;
  localparam logic [3:0] OP_READ_B2B = 4'h2;
  localparam logic [3:0] OP_READ_CLR = 4'h3;
  localparam logic [3:0] OP_END = 4'hf;

  logic               clk_i;
  logic               rst_ni;
  logic               clear_i;
  logic               req_i;
  logic [AW-1:0]      add_i;
  logic               wen_i;
  logic [WIDE_BW-1:0] be_i;
  logic [WIDE_DW-1:0] data_i;
  logic               gnt_o;
  logic [WIDE_DW-1:0] r_data_o;
  logic               r_valid_o;

  logic [WIDE_DW-1:0] pat_mem [FIELDS*MAX_STEPS];
  // read data still owed by the DUT in grant order
  logic [WIDE_DW-1:0] exp_q [$];
  int unsigned        error_count;
  int unsigned        read_grants;
  int unsigned        rvalid_count;
  int unsigned        dropped_reads;
  integer             seed;

  banked_mem_top #(
    .NB_BANKS  (NB_BANKS),
    .WIDE_DW   (WIDE_DW),
    .ROW_AW    (ROW_AW),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) dut_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .req_i    (req_i),
    .add_i    (add_i),
    .wen_i    (wen_i),
    .be_i     (be_i),
    .data_i   (data_i),
    .gnt_o    (gnt_o),
    .r_data_o (r_data_o),
    .r_valid_o(r_valid_o)
  );

  // 4 ns clock
  always #2 clk_i = ~clk_i;

  task automatic check_equal(input logic [WIDE_DW-1:0] got, input logic [WIDE_DW-1:0] exp,
                             input string what);
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("errors: %0d", error_count + 1);
    $display("TEST FAILED");
    $finish;
  endtask

  // every step of the driver ends 1 ns after a rising edge
  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic issue_request(input logic [3:0] op, input logic [AW-1:0] addr,
                               input logic [WIDE_BW-1:0] be, input logic [WIDE_DW-1:0] wdata,
                               input logic [WIDE_DW-1:0] exp);
    int unsigned waited;
    logic        granted;
    waited  = 0;
    granted = 1'b0;
    req_i   = 1'b1;
    add_i   = addr;
    wen_i   = (op != OP_WRITE);
    be_i    = be;
    data_i  = wdata;
    // look for the grant at the falling edge
    while (!granted) begin
      @(negedge clk_i);
      if (gnt_o) begin
        granted = 1'b1;
      end else begin
        waited++;
        if (waited > TIMEOUT) stop_on_timeout("gnt_o never went high for a pending request");
      end
    end
    // handshake completes on this edge
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    if (wen_i) begin
      read_grants++;
      exp_q.push_back(exp);
    end
  endtask

  task automatic wait_responses_drained();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > TIMEOUT) stop_on_timeout("read responses never arrived");
    end
  endtask

  // clear on the edge after the grant drops the response of this read
  task automatic read_then_clear(input logic [AW-1:0] addr);
    wait_responses_drained();
    issue_request(OP_READ_CLR, addr, '0, '0, '0);
    clear_i = 1'b1;
    dropped_reads += exp_q.size();
    exp_q.delete();
    idle_cycles(1);
    clear_i = 1'b0;
    // response checker flags any r_valid_o in this window
    idle_cycles(6);
  endtask

  // in-order response checker against the queue
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni && r_valid_o) begin
        rvalid_count++;
        if (exp_q.size() == 0) begin
          error_count++;
          $display("unexpected response at %0t: r_valid_o high with no read pending", $time);
        end else begin
          check_equal(r_data_o, exp_q.pop_front(), "read data");
        end
      end
    end
  end

  initial begin
    int unsigned base;
    int unsigned step;
    int unsigned gap;
    logic        done;
    logic [3:0]  op;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    req_i         = 1'b0;
    add_i         = '0;
    wen_i         = 1'b1;
    be_i          = '0;
    data_i        = '0;
    error_count   = 0;
    read_grants   = 0;
    rvalid_count  = 0;
    dropped_reads = 0;
    seed          = 32'h5d60;
    $readmemh("verif/wide_access_patterns.txt", pat_mem);

    // reset held over three rising edges
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    idle_cycles(2);

    step = 0;
    done = 1'b0;
    while (!done) begin
      base = FIELDS * step;
      op   = pat_mem[base][3:0];
      case (op)
        OP_END: begin
          done = 1'b1;
        end
        OP_READ_B2B: begin
          issue_request(op, pat_mem[base+1][AW-1:0], pat_mem[base+2][WIDE_BW-1:0],
                        pat_mem[base+3], pat_mem[base+4]);
        end
        OP_READ_CLR: begin
          read_then_clear(pat_mem[base+1][AW-1:0]);
        end
        OP_WRITE, OP_READ: begin
          // random idle gap of 0 to 2 cycles
          gap = $unsigned($random(seed)) % 3;
          idle_cycles(gap);
          issue_request(op, pat_mem[base+1][AW-1:0], pat_mem[base+2][WIDE_BW-1:0],
                        pat_mem[base+3], pat_mem[base+4]);
        end
        default: begin
          error_count++;
          $display("pattern line %0d holds an unknown operation %h", step, op);
          done = 1'b1;
        end
      endcase
      step++;
      if (step >= MAX_STEPS) begin
        done = 1'b1;
      end
    end

    wait_responses_drained();
    idle_cycles(4);
    // one pulse per read that was granted and not cleared
    check_equal(WIDE_DW'(rvalid_count), WIDE_DW'(read_grants - dropped_reads),
                "response count");
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/wide_access_patterns.txt ====
// columns: op addr be wdata exp_rdata, all hex, lane 3 is the leftmost word
// op: 0 write, 1 read, 2 read with no idle gap, 3 read then clear, f end
// aligned write and read, row 1, bank offset 0
0 020 ffff 13579bdf2468ace00f1e2d3c4b5a6978 0
1 020 0 0 13579bdf2468ace00f1e2d3c4b5a6978
// prefill row 2 banks 0-3, row 2 banks 4-7, row 3 banks 0-3
0 040 ffff 02035a5a02025a5a02015a5a02005a5a 0
0 050 ffff 02075a5a02065a5a02055a5a02045a5a 0
0 060 ffff 03035a5a03025a5a03015a5a03005a5a 0
// bank offset 6, lanes 2 and 3 wrap into row 3
0 058 ffff e3010004e3000003e2070002e2060001 0
1 058 0 0 e3010004e3000003e2070002e2060001
1 060 0 0 03035a5a03025a5ae3010004e3000003
1 050 0 0 e2070002e206000102055a5a02045a5a
1 040 0 0 02035a5a02025a5a02015a5a02005a5a
// partial write, lane 1 untouched, lanes 2 and 3 merge bytes
0 020 5a0f eeeeeeeeddddddddccccccccbbbbbbbb 0
1 020 0 0 13ee9beedd68dde00f1e2d3cbbbbbbbb
// back-to-back reads
2 020 0 0 13ee9beedd68dde00f1e2d3cbbbbbbbb
2 058 0 0 e3010004e3000003e2070002e2060001
2 060 0 0 03035a5a03025a5ae3010004e3000003
2 050 0 0 e2070002e206000102055a5a02045a5a
2 040 0 0 02035a5a02025a5a02015a5a02005a5a
// clear mid-stream, memory keeps its contents
3 058 0 0 0
1 058 0 0 e3010004e3000003e2070002e2060001
1 020 0 0 13ee9beedd68dde00f1e2d3cbbbbbbbb
f 000 0 0 0
